//--- design/if_cap_check.sv
`timescale 1ns/1ns

module if_cap_check import if_pkg::*; (
  input  logic       fetch_valid_i,
  input  fetch_out_t fetch_i,
  input  pcc_cap_t   pcc_cap_i,
  input  logic       cheri_pmode_i,
  input  logic       debug_mode_i,
  output logic       acc_vio_o
);

  logic [ADDR_W:0] hdrm;
  logic            below_base;
  logic            hdrm_bad;
  logic            perm_bad;
  logic            check_en;

  // room left between the fetch address and the top of the capability
  assign hdrm       = pcc_cap_i.top33 - {1'b0, fetch_i.addr};
  assign below_base = (fetch_i.addr < pcc_cap_i.base);
  // msb set means the address is already past top
  assign hdrm_bad   = hdrm[ADDR_W] | (hdrm < (ADDR_W + 1)'(INSTR_BYTES));

  // execute permission, tag and unsealed object type
  assign perm_bad = ~pcc_cap_i.perm_ex | ~pcc_cap_i.valid | (pcc_cap_i.otype != '0);

  // only real words in capability mode, debug code runs unchecked
  // a word with a bus error already faults and is left alone
  assign check_en = cheri_pmode_i & ~debug_mode_i & fetch_valid_i & ~fetch_i.bus_err;

  assign acc_vio_o = check_en & (below_base | hdrm_bad | perm_bad);

endmodule

//--- design/if_fetch_unit.sv
`timescale 1ns/1ns

module if_fetch_unit import if_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       req_i,
  input  logic       pc_set_i,
  input  addr_t      fetch_addr_n_i,
  input  logic       fetch_ready_i,
  output logic       fetch_valid_o,
  output fetch_out_t fetch_o,
  output logic       instr_req_o,
  output addr_t      instr_addr_o,
  input  logic       instr_gnt_i,
  input  logic       instr_rvalid_i,
  input  instr_t     instr_rdata_i,
  input  logic       instr_err_i,
  output logic       busy_o
);

  fetch_state_e state_q, state_d;
  logic         discard_q, discard_d;
  logic         armed_q, armed_d;
  logic         held_valid_q, held_valid_d;
  logic         held_we;
  logic         accept;
  fetch_out_t   held_q;
  addr_t        req_addr_q, req_addr_d;
  addr_t        next_addr_q, next_addr_d;
  addr_t        load_addr;

  // all fetches are whole words
  assign load_addr = {fetch_addr_n_i[ADDR_W-1:2], 2'b00};
  assign accept    = held_valid_q & fetch_ready_i;

  ////////////////////////////////////////////////////////////
  // request FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    discard_d    = discard_q;
    // nothing is fetched until the first redirect after reset
    armed_d      = armed_q | pc_set_i;
    // a redirect throws the held word away
    held_valid_d = held_valid_q & ~accept & ~pc_set_i;
    held_we      = 1'b0;
    req_addr_d   = req_addr_q;
    next_addr_d  = pc_set_i ? load_addr : next_addr_q;

    unique case (state_q)
      FETCH_IDLE: begin
        if (req_i && pc_set_i) begin
          state_d    = FETCH_WAIT_GNT;
          req_addr_d = load_addr;
        end else if (req_i && armed_q && (!held_valid_q || accept)) begin
          // one word in flight, the next goes out once the held one is taken
          state_d    = FETCH_WAIT_GNT;
          req_addr_d = next_addr_q;
        end
      end
      FETCH_WAIT_GNT: begin
        // address must stay put until grant, so a redirect only marks the request
        discard_d = discard_q | pc_set_i;
        if (instr_gnt_i) begin
          state_d = FETCH_WAIT_RVALID;
          if (!discard_q && !pc_set_i) begin
            next_addr_d = req_addr_q + addr_t'(INSTR_BYTES);
          end
        end
      end
      FETCH_WAIT_RVALID: begin
        if (!instr_rvalid_i) begin
          discard_d = discard_q | pc_set_i;
        end else if (discard_q || pc_set_i) begin
          // stale response, restart at the redirect target
          discard_d = 1'b0;
          if (req_i) begin
            state_d    = FETCH_WAIT_GNT;
            req_addr_d = next_addr_d;
          end else begin
            state_d = FETCH_IDLE;
          end
        end else begin
          held_valid_d = 1'b1;
          held_we      = 1'b1;
          state_d      = FETCH_IDLE;
        end
      end
      default: state_d = FETCH_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= FETCH_IDLE;
      discard_q    <= 1'b0;
      armed_q      <= 1'b0;
      held_valid_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      discard_q    <= discard_d;
      armed_q      <= armed_d;
      held_valid_q <= held_valid_d;
    end
  end

  // addresses and the held word
  always_ff @(posedge clk_i) begin
    req_addr_q  <= req_addr_d;
    next_addr_q <= next_addr_d;
    if (held_we) begin
      held_q <= '{rdata: instr_rdata_i, addr: req_addr_q, bus_err: instr_err_i};
    end
  end

  assign instr_req_o   = (state_q == FETCH_WAIT_GNT);
  assign instr_addr_o  = req_addr_q;
  assign fetch_valid_o = held_valid_q;
  assign fetch_o       = held_q;
  assign busy_o        = (state_q != FETCH_IDLE) | held_valid_q;

endmodule

//--- design/if_id_reg.sv
`timescale 1ns/1ns

module if_id_reg import if_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       fetch_valid_i,
  input  fetch_out_t fetch_i,
  input  logic       acc_vio_i,
  input  logic       pmp_err_i,
  input  logic       id_in_ready_i,
  input  logic       pc_set_i,
  input  logic       instr_valid_clear_i,
  output logic       instr_valid_id_o,
  output logic       instr_new_id_o,
  output instr_t     instr_rdata_id_o,
  output logic       instr_fetch_err_o,
  output addr_t      pc_id_o,
  output logic       pc_mismatch_alert_o
);

  logic  transfer;
  logic  fetch_err;
  logic  valid_d;
  logic  seq_q, seq_d;
  addr_t pc_id_incr;

  // fetch unit hands over a word in this cycle
  assign transfer  = fetch_valid_i & id_in_ready_i;
  // bus, pmp and capability faults all look the same to ID
  assign fetch_err = fetch_i.bus_err | pmp_err_i | acc_vio_i;

  // a redirect in the transfer cycle squashes the word
  // valid then holds until ID clears it
  assign valid_d = (transfer & ~pc_set_i) | (instr_valid_id_o & ~instr_valid_clear_i);

  ////////////////////////////////////////////////////////////
  // IF-ID pipeline register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_valid_id_o  <= 1'b0;
      instr_new_id_o    <= 1'b0;
      instr_rdata_id_o  <= '0;
      instr_fetch_err_o <= 1'b0;
      pc_id_o           <= '0;
    end else begin
      instr_valid_id_o <= valid_d;
      instr_new_id_o   <= transfer;
      // frozen while ID stalls
      if (transfer) begin
        instr_rdata_id_o  <= fetch_i.rdata;
        instr_fetch_err_o <= fetch_err;
        pc_id_o           <= fetch_i.addr;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // pc increment check
  ////////////////////////////////////////////////////////////

  // no check across a redirect or after a faulting fetch
  assign seq_d = (seq_q | transfer) & ~pc_set_i & ~(fetch_valid_i & fetch_err);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seq_q <= 1'b0;
    end else begin
      seq_q <= seq_d;
    end
  end

  assign pc_id_incr = pc_id_o + addr_t'(INSTR_BYTES);

  // held address is stale between words, so only look at a valid one
  assign pc_mismatch_alert_o = seq_q & fetch_valid_i & (fetch_i.addr != pc_id_incr);

endmodule

//--- design/if_pc_sel.sv
`timescale 1ns/1ns

module if_pc_sel import if_pkg::*; (
  input  pc_sel_e     pc_mux_i,
  input  exc_pc_sel_e exc_pc_mux_i,
  input  exc_cause_t  exc_cause_i,
  input  addr_t       boot_addr_i,
  input  addr_t       branch_target_i,
  input  addr_t       csr_mepc_i,
  input  addr_t       csr_depc_i,
  input  addr_t       csr_mtvec_i,
  input  logic        cheri_pmode_i,
  input  logic        pc_set_i,
  output addr_t       fetch_addr_n_o,
  output logic        csr_mtvec_init_o
);

  logic  vec_mode;
  addr_t vec_base;
  addr_t word_base;
  addr_t irq_off;
  addr_t boot_pc;
  addr_t exc_pc;

  // mtvec bit 0 selects the 256-byte table, legacy mode always uses it
  assign vec_mode  = csr_mtvec_i[0] | ~cheri_pmode_i;
  assign vec_base  = {csr_mtvec_i[ADDR_W-1:VEC_ALIGN_BITS], {VEC_ALIGN_BITS{1'b0}}};
  assign word_base = {csr_mtvec_i[ADDR_W-1:2], 2'b00};
  // one word per interrupt slot
  assign irq_off   = addr_t'(exc_cause_i) * addr_t'(INSTR_BYTES);
  assign boot_pc   = {boot_addr_i[ADDR_W-1:VEC_ALIGN_BITS], {VEC_ALIGN_BITS{1'b0}}} + BOOT_OFFSET;

  // handler address
  always_comb begin
    unique case (exc_pc_mux_i)
      EXC_PC_EXC:     exc_pc = vec_mode ? vec_base : word_base;
      EXC_PC_IRQ:     exc_pc = vec_mode ? (vec_base | irq_off) : word_base;
      EXC_PC_DBD:     exc_pc = DM_HALT_ADDR;
      EXC_PC_DBG_EXC: exc_pc = DM_EXC_ADDR;
      default:        exc_pc = vec_base;
    endcase
  end

  // next fetch address, only looked at by the fetch unit on pc_set_i
  always_comb begin
    unique case (pc_mux_i)
      PC_BOOT: fetch_addr_n_o = boot_pc;
      PC_JUMP: fetch_addr_n_o = branch_target_i;
      PC_EXC:  fetch_addr_n_o = exc_pc;
      // return from trap
      PC_ERET: fetch_addr_n_o = csr_mepc_i;
      // return from debug mode
      PC_DRET: fetch_addr_n_o = csr_depc_i;
      default: fetch_addr_n_o = boot_pc;
    endcase
  end

  // csr file loads its mtvec reset value on the boot jump
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == PC_BOOT);

endmodule

//--- design/if_pkg.sv
package if_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned INSTR_W = 32;
  localparam int unsigned CAUSE_W = 5;
  localparam int unsigned OTYPE_W = 3;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [INSTR_W-1:0] instr_t;
  // interrupt id, selects the vectored handler slot
  typedef logic [CAUSE_W-1:0] exc_cause_t;

  ////////////////////////////////////////////////////////////
  // address map
  ////////////////////////////////////////////////////////////

  // debug module entry points
  localparam addr_t DM_HALT_ADDR = 32'h1A11_0800;
  localparam addr_t DM_EXC_ADDR = 32'h1A11_0808;
  // first fetch sits this far above the aligned boot base
  localparam addr_t BOOT_OFFSET = 32'h0000_0080;
  // mtvec and boot base are 256-byte aligned
  localparam int unsigned VEC_ALIGN_BITS = 8;
  // no compressed instructions, every fetch is one word
  localparam int unsigned INSTR_BYTES = 4;

  ////////////////////////////////////////////////////////////
  // selectors and state
  ////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    PC_BOOT,
    PC_JUMP,
    PC_EXC,
    PC_ERET,
    PC_DRET
  } pc_sel_e;

  typedef enum logic [1:0] {
    EXC_PC_EXC,
    EXC_PC_IRQ,
    EXC_PC_DBD,
    EXC_PC_DBG_EXC
  } exc_pc_sel_e;

  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_WAIT_GNT,
    FETCH_WAIT_RVALID
  } fetch_state_e;

  // program counter capability, top is one bit wider than an address
  typedef struct packed {
    addr_t              base;
    logic [ADDR_W:0]    top33;
    logic               perm_ex;
    logic               valid;
    logic [OTYPE_W-1:0] otype;
  } pcc_cap_t;

  // word handed from the fetch unit to the IF-ID register
  typedef struct packed {
    instr_t rdata;
    addr_t  addr;
    logic   bus_err;
  } fetch_out_t;

endpackage

//--- design/if_stage.sv
`timescale 1ns/1ns

module if_stage import if_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        req_i,
  input  logic        cheri_pmode_i,
  input  logic        debug_mode_i,
  input  addr_t       boot_addr_i,
  // instruction bus
  output logic        instr_req_o,
  output addr_t       instr_addr_o,
  input  logic        instr_gnt_i,
  input  logic        instr_rvalid_i,
  input  instr_t      instr_rdata_i,
  input  logic        instr_err_i,
  // to ID
  output logic        instr_valid_id_o,
  output logic        instr_new_id_o,
  output instr_t      instr_rdata_id_o,
  output logic        instr_fetch_err_o,
  output addr_t       pc_if_o,
  output addr_t       pc_id_o,
  input  logic        pmp_err_i,
  // control from ID
  input  logic        instr_valid_clear_i,
  input  logic        pc_set_i,
  input  pc_sel_e     pc_mux_i,
  input  exc_pc_sel_e exc_pc_mux_i,
  input  exc_cause_t  exc_cause_i,
  input  addr_t       branch_target_i,
  // csrs
  input  addr_t       csr_mepc_i,
  input  addr_t       csr_depc_i,
  input  addr_t       csr_mtvec_i,
  output logic        csr_mtvec_init_o,
  input  logic        id_in_ready_i,
  output logic        pc_mismatch_alert_o,
  output logic        if_busy_o,
  input  pcc_cap_t    pcc_cap_i
);

  addr_t      fetch_addr_n;
  logic       fetch_valid;
  fetch_out_t fetch_out;
  logic       cheri_acc_vio;

  // fetch pc is the address of the held word
  assign pc_if_o = fetch_out.addr;

  if_pc_sel u_pc_sel (
    .pc_mux_i, .exc_pc_mux_i, .exc_cause_i, .boot_addr_i, .branch_target_i,
    .csr_mepc_i, .csr_depc_i, .csr_mtvec_i, .cheri_pmode_i, .pc_set_i,
    .fetch_addr_n_o   (fetch_addr_n),
    .csr_mtvec_init_o
  );

  // ID readiness is the only back-pressure on the fetch unit
  if_fetch_unit u_fetch_unit (
    .clk_i, .rst_ni, .req_i, .pc_set_i,
    .fetch_addr_n_i (fetch_addr_n),
    .fetch_ready_i  (id_in_ready_i),
    .fetch_valid_o  (fetch_valid),
    .fetch_o        (fetch_out),
    .instr_req_o, .instr_addr_o, .instr_gnt_i, .instr_rvalid_i,
    .instr_rdata_i, .instr_err_i,
    .busy_o         (if_busy_o)
  );

  if_cap_check u_cap_check (
    .fetch_valid_i  (fetch_valid),
    .fetch_i        (fetch_out),
    .pcc_cap_i, .cheri_pmode_i, .debug_mode_i,
    .acc_vio_o      (cheri_acc_vio)
  );

  if_id_reg u_id_reg (
    .clk_i, .rst_ni,
    .fetch_valid_i  (fetch_valid),
    .fetch_i        (fetch_out),
    .acc_vio_i      (cheri_acc_vio),
    .pmp_err_i, .id_in_ready_i, .pc_set_i, .instr_valid_clear_i,
    .instr_valid_id_o, .instr_new_id_o, .instr_rdata_id_o, .instr_fetch_err_o,
    .pc_id_o, .pc_mismatch_alert_o
  );

endmodule

//--- list.f
design/if_pkg.sv
design/if_pc_sel.sv
design/if_fetch_unit.sv
design/if_cap_check.sv
design/if_id_reg.sv
design/if_stage.sv
test/if_stage_chk.sv
test/tb_if_stage.sv

//--- run.sh
#!/bin/sh
# build and run the IF stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_if_stage -f list.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_if_stage > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Some tests failed" sim.log; then
  exit 1
fi
exit 0

//--- test/if_stage_chk.sv
`timescale 1ns/1ns

module if_stage_chk import if_pkg::*; (
  input logic  clk_i,
  input logic  rst_ni,
  input logic  instr_req_o,
  input addr_t instr_addr_o,
  input logic  instr_gnt_i,
  input logic  instr_valid_id_o,
  input logic  instr_new_id_o,
  input logic  pc_mismatch_alert_o
);

  ////////////////////////////////////////////////////////////
  // instruction bus
  ////////////////////////////////////////////////////////////

  // whole words only
  req_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o |-> (instr_addr_o[1:0] == 2'b00))
    else $error("instr_addr_o not word aligned");

  // request and address held until granted
  req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (instr_req_o && !instr_gnt_i) |=> (instr_req_o && $stable(instr_addr_o)))
    else $error("instruction request dropped or moved before grant");

  ////////////////////////////////////////////////////////////
  // IF-ID outputs
  ////////////////////////////////////////////////////////////

  new_is_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_new_id_o |-> instr_valid_id_o)
    else $error("instr_new_id_o without instr_valid_id_o");

  // every fetch run here is sequential
  no_alert: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !pc_mismatch_alert_o)
    else $error("pc mismatch alert raised");

endmodule

//--- test/tb_if_stage.sv
`timescale 1ns/1ns

module tb_if_stage import if_pkg::*; ();

  // memory returns the fetch address xor this pattern
  localparam instr_t RDATA_XOR   = 32'hA5A5_A5A5;
  // addresses that answer with a bus error
  localparam addr_t  ERR_LO      = 32'h0000_3000;
  localparam addr_t  ERR_HI      = 32'h0000_30FF;
  localparam int     ROW_TIMEOUT = 200;

  typedef struct packed {
    pc_sel_e     pc_mux;
    exc_pc_sel_e exc_mux;
    exc_cause_t  cause;
    // drives both the jump target and mtvec
    addr_t       src;
    pcc_cap_t    cap;
    // {cheri_pmode, debug_mode, pmp_err}
    logic [2:0]  flags;
    // id_in_ready_i per cycle indexed by cycle mod 8
    logic [7:0]  ready;
    logic [3:0]  nwords;
    addr_t       exp_pc;
    logic        exp_err;
  } row_t;

  logic        clk_i = 1'b0;
  logic        rst_ni, req_i, cheri_pmode_i, debug_mode_i, pmp_err_i;
  logic        instr_valid_clear_i, pc_set_i, id_in_ready_i;
  addr_t       boot_addr_i, branch_target_i, csr_mepc_i, csr_depc_i, csr_mtvec_i;
  pc_sel_e     pc_mux_i;
  exc_pc_sel_e exc_pc_mux_i;
  exc_cause_t  exc_cause_i;
  pcc_cap_t    pcc_cap_i;
  logic        instr_gnt_i = 1'b0;
  logic        instr_rvalid_i = 1'b0;
  instr_t      instr_rdata_i = '0;
  logic        instr_err_i = 1'b0;
  logic        instr_req_o, instr_valid_id_o, instr_new_id_o, instr_fetch_err_o;
  logic        csr_mtvec_init_o, pc_mismatch_alert_o, if_busy_o;
  addr_t       instr_addr_o, pc_if_o, pc_id_o;
  instr_t      instr_rdata_id_o;

  // memory model state
  integer      seed = 67;
  int          gnt_dly = 0;
  int          rv_dly = 0;
  addr_t       pend_addr = '0;

  int          fail_cnt = 0;
  int          init_cnt = 0;
  int          rows_run = 0;
  logic        timed_out = 1'b0;
  row_t        rows[$];
  pcc_cap_t    cap_ok, cap_lo, cap_hi, cap_edge, cap_nox, cap_tag, cap_otp;

  always #4 clk_i = ~clk_i;

  if_stage uut (.*);

  bind if_stage if_stage_chk u_chk (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .instr_req_o         (instr_req_o),
    .instr_addr_o        (instr_addr_o),
    .instr_gnt_i         (instr_gnt_i),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .pc_mismatch_alert_o (pc_mismatch_alert_o)
  );

  always @(posedge clk_i) begin
    if (csr_mtvec_init_o) begin
      init_cnt++;
    end
  end

  ////////////////////////////////////////////////////////////
  // instruction memory with random grant and rvalid delay
  ////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    if (rv_dly > 0) begin
      rv_dly = rv_dly - 1;
      if (rv_dly == 0) begin
        instr_rvalid_i = 1'b1;
        instr_rdata_i  = pend_addr ^ RDATA_XOR;
        instr_err_i    = (pend_addr >= ERR_LO) && (pend_addr <= ERR_HI);
      end
    end else if (instr_req_o) begin
      if (gnt_dly == 0) begin
        instr_gnt_i = 1'b1;
        pend_addr   = instr_addr_o;
        // rvalid 1..2 cycles after grant and the next grant 0..2 cycles late
        rv_dly      = 1 + int'($unsigned($random(seed)) % 2);
        gnt_dly     = int'($unsigned($random(seed)) % 3);
      end else begin
        gnt_dly = gnt_dly - 1;
      end
    end
  end

  task automatic add_row(input pc_sel_e pm, input exc_pc_sel_e em, input exc_cause_t cause,
                         input addr_t src, input pcc_cap_t cap, input logic [2:0] flags,
                         input logic [7:0] ready, input int n, input addr_t pc,
                         input logic err);
    rows.push_back(row_t'{pm, em, cause, src, cap, flags, ready, n[3:0], pc, err});
  endtask

  task automatic check_eq(input int idx, input string what, input logic [31:0] got,
                          input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %0t row %0d %s is %h, expected %h", $time, idx, what, got, exp);
      fail_cnt++;
    end
  endtask

  // nothing is fetched and nothing reaches ID before the boot redirect
  task automatic check_reset();
    @(negedge clk_i);
    if (instr_req_o || instr_valid_id_o || instr_new_id_o || pc_mismatch_alert_o ||
        csr_mtvec_init_o || if_busy_o) begin
      $display("[FAIL] %0t outputs not idle after reset: req %b valid %b new %b",
               $time, instr_req_o, instr_valid_id_o, instr_new_id_o);
      $display("[FAIL] %0t outputs not idle after reset: alert %b init %b busy %b",
               $time, pc_mismatch_alert_o, csr_mtvec_init_o, if_busy_o);
      fail_cnt++;
      $display("reset: mismatch");
    end else begin
      $display("reset: ok");
    end
  endtask

  // valid drops on the clear pulse and stays low while ID takes nothing
  task automatic clear_valid(input int idx);
    @(negedge clk_i);
    check_eq(idx, "valid before clear", 32'(instr_valid_id_o), 32'd1);
    instr_valid_clear_i = 1'b1;
    @(negedge clk_i);
    instr_valid_clear_i = 1'b0;
    repeat (3) begin
      check_eq(idx, "valid after clear", 32'(instr_valid_id_o), 32'd0);
      @(negedge clk_i);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // one row redirects and then collects nwords instructions
  ////////////////////////////////////////////////////////////

  task automatic run_row(input int idx);
    row_t   r;
    int     cyc;
    int     w;
    int     errs_before;
    logic   prev_rdy;
    addr_t  last_pc;
    instr_t last_rdata;
    addr_t  exp_pc;
    r           = rows[idx];
    cyc         = 0;
    w           = 0;
    errs_before = fail_cnt;
    // ID accepts nothing in the redirect cycle
    @(negedge clk_i);
    pc_mux_i        = r.pc_mux;
    exc_pc_mux_i    = r.exc_mux;
    exc_cause_i     = r.cause;
    branch_target_i = r.src;
    csr_mtvec_i     = r.src;
    pcc_cap_i       = r.cap;
    {cheri_pmode_i, debug_mode_i, pmp_err_i} = r.flags;
    pc_set_i        = 1'b1;
    id_in_ready_i   = 1'b0;
    prev_rdy        = 1'b0;
    last_pc         = pc_id_o;
    last_rdata      = instr_rdata_id_o;
    while ((w < int'(r.nwords)) && (cyc < ROW_TIMEOUT)) begin
      @(negedge clk_i);
      pc_set_i = 1'b0;
      cyc++;
      check_eq(idx, "pc_mismatch_alert", 32'(pc_mismatch_alert_o), 32'd0);
      // req_i stays high so the fetch unit is never idle with nothing held
      check_eq(idx, "if_busy", 32'(if_busy_o), 32'd1);
      // a stalled ID sees no new word and no change on its outputs
      if (!prev_rdy && (instr_new_id_o || (pc_id_o != last_pc) ||
                        (instr_rdata_id_o != last_rdata))) begin
        $display("[FAIL] %0t row %0d ID outputs changed while stalled", $time, idx);
        fail_cnt++;
      end
      if (instr_new_id_o) begin
        exp_pc = r.exp_pc + addr_t'(4 * w);
        check_eq(idx, "pc_id", pc_id_o, exp_pc);
        // the held word just handed over is still the fetch pc
        check_eq(idx, "pc_if", pc_if_o, exp_pc);
        check_eq(idx, "rdata", instr_rdata_id_o, exp_pc ^ RDATA_XOR);
        check_eq(idx, "fetch_err", 32'(instr_fetch_err_o), 32'(r.exp_err));
        check_eq(idx, "valid", 32'(instr_valid_id_o), 32'd1);
        last_pc    = pc_id_o;
        last_rdata = instr_rdata_id_o;
        w++;
      end
      prev_rdy      = (w < int'(r.nwords)) && r.ready[cyc % 8];
      id_in_ready_i = prev_rdy;
    end
    if (w < int'(r.nwords)) begin
      $display("row %0d timed out with only %0d of %0d instructions received", idx, w,
               r.nwords);
      fail_cnt++;
      timed_out = 1'b1;
    end else begin
      clear_valid(idx);
      $display("row %0d pc %h: %0d words, %s", idx, r.exp_pc, w,
               (fail_cnt == errs_before) ? "ok" : "mismatch");
    end
  endtask

  initial begin
    rst_ni              = 1'b0;
    req_i               = 1'b1;
    cheri_pmode_i       = 1'b1;
    debug_mode_i        = 1'b0;
    pmp_err_i           = 1'b0;
    instr_valid_clear_i = 1'b0;
    pc_set_i            = 1'b0;
    id_in_ready_i       = 1'b0;
    boot_addr_i         = 32'h0000_1000;
    branch_target_i     = '0;
    csr_mepc_i          = 32'h0000_2400;
    csr_depc_i          = 32'h0000_2800;
    csr_mtvec_i         = '0;
    pc_mux_i            = PC_BOOT;
    exc_pc_mux_i        = EXC_PC_EXC;
    exc_cause_i         = '0;

    // full address space that is executable, tagged and unsealed
    cap_ok = '{base: '0, top33: 33'h1_0000_0000, perm_ex: 1'b1, valid: 1'b1, otype: '0};
    pcc_cap_i      = cap_ok;
    cap_lo         = cap_ok;
    cap_lo.base    = 32'h0000_5000;
    cap_hi         = cap_ok;
    cap_hi.top33   = 33'h0_0000_2002;
    cap_edge       = cap_ok;
    cap_edge.top33 = 33'h0_0000_2004;
    cap_nox        = cap_ok;
    cap_nox.perm_ex = 1'b0;
    cap_tag        = cap_ok;
    cap_tag.valid  = 1'b0;
    cap_otp        = cap_ok;
    cap_otp.otype  = 3'd3;

    add_row(PC_BOOT, EXC_PC_EXC, 5'd0, 32'h0, cap_ok, 3'b100, 8'hFF, 4, 32'h1080, 1'b0);
    add_row(PC_JUMP, EXC_PC_EXC, 5'd0, 32'h2000, cap_ok, 3'b100, 8'h81, 4, 32'h2000, 1'b0);
    add_row(PC_ERET, EXC_PC_EXC, 5'd0, 32'h0, cap_ok, 3'b100, 8'hFF, 2, 32'h2400, 1'b0);
    add_row(PC_DRET, EXC_PC_EXC, 5'd0, 32'h0, cap_ok, 3'b100, 8'hFF, 2, 32'h2800, 1'b0);
    add_row(PC_EXC, EXC_PC_EXC, 5'd0, 32'h4105, cap_ok, 3'b100, 8'hFF, 2, 32'h4100, 1'b0);
    add_row(PC_EXC, EXC_PC_EXC, 5'd0, 32'h4106, cap_ok, 3'b100, 8'hFF, 2, 32'h4104, 1'b0);
    add_row(PC_EXC, EXC_PC_EXC, 5'd0, 32'h4106, cap_ok, 3'b000, 8'hFF, 2, 32'h4100, 1'b0);
    add_row(PC_EXC, EXC_PC_IRQ, 5'd5, 32'h4101, cap_ok, 3'b100, 8'hFF, 2, 32'h4114, 1'b0);
    add_row(PC_EXC, EXC_PC_IRQ, 5'd5, 32'h4104, cap_ok, 3'b100, 8'hFF, 1, 32'h4104, 1'b0);
    add_row(PC_EXC, EXC_PC_DBD, 5'd0, 32'h0, cap_ok, 3'b100, 8'hFF, 2, DM_HALT_ADDR, 1'b0);
    add_row(PC_EXC, EXC_PC_DBG_EXC, 5'd0, 32'h0, cap_ok, 3'b110, 8'hFF, 1, DM_EXC_ADDR, 1'b0);
    // bus error window and pmp
    add_row(PC_JUMP, EXC_PC_EXC, 5'd0, 32'h3000, cap_ok, 3'b100, 8'hFF, 2, 32'h3000, 1'b1);
    add_row(PC_JUMP, EXC_PC_EXC, 5'd0, 32'h3100, cap_ok, 3'b100, 8'hFF, 2, 32'h3100, 1'b0);
    add_row(PC_JUMP, EXC_PC_EXC, 5'd0, 32'h2000, cap_ok, 3'b101, 8'hFF, 1, 32'h2000, 1'b1);
    // capability faults and then the same faults with the check off
    add_row(PC_JUMP, EXC_PC_EXC, 5'd0, 32'h2000, cap_lo, 3'b100, 8'hFF, 1, 32'h2000, 1'b1);
    add_row(PC_JUMP, EXC_PC_EXC, 5'd0, 32'h2000, cap_hi, 3'b100, 8'hFF, 1, 32'h2000, 1'b1);
    add_row(PC_JUMP, EXC_PC_EXC, 5'd0, 32'h2000, cap_edge, 3'b100, 8'hFF, 1, 32'h2000, 1'b0);
    add_row(PC_JUMP, EXC_PC_EXC, 5'd0, 32'h2000, cap_nox, 3'b100, 8'hFF, 1, 32'h2000, 1'b1);
    add_row(PC_JUMP, EXC_PC_EXC, 5'd0, 32'h2000, cap_tag, 3'b100, 8'hFF, 1, 32'h2000, 1'b1);
    add_row(PC_JUMP, EXC_PC_EXC, 5'd0, 32'h2000, cap_otp, 3'b100, 8'hFF, 1, 32'h2000, 1'b1);
    add_row(PC_JUMP, EXC_PC_EXC, 5'd0, 32'h2000, cap_nox, 3'b000, 8'hFF, 1, 32'h2000, 1'b0);
    add_row(PC_JUMP, EXC_PC_EXC, 5'd0, 32'h2000, cap_tag, 3'b110, 8'hFF, 1, 32'h2000, 1'b0);

    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    check_reset();

    for (int i = 0; (i < rows.size()) && !timed_out; i++) begin
      run_row(i);
      rows_run++;
    end

    // only the boot row loads mtvec
    check_eq(0, "csr_mtvec_init pulse count", 32'(init_cnt), 32'd1);
    $display("%0d of %0d rows run, %0d checks failed", rows_run, rows.size(), fail_cnt);
    if (fail_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
